/* common/rvseed_pkg.sv */
package rvseed_pkg;

	// data path and register file geometry
	localparam int cpu_width      = 64;
	localparam int reg_addr_width = 5;
	localparam int ram_depth_log2 = 8;	// 256 doublewords

	localparam logic [31:0] reset_pc = 32'h8000_0000;

	typedef logic [cpu_width-1:0]      xlen_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;
	typedef logic [7:0]                wmask_t;	// 01/03/0F/FF, zero means no store
	typedef logic [31:0]               imm_t;
	typedef logic [31:0]               pc_t;

	// load extension code, carried as expand_signed
	typedef enum logic [3:0] {
		ext_b  = 4'd0,
		ext_bu = 4'd1,
		ext_h  = 4'd2,
		ext_hu = 4'd3,
		ext_w  = 4'd4,
		ext_wu = 4'd5,
		ext_d  = 4'd6
	} ext_e;

	// writeback source, rd_buf_flag
	typedef enum logic [2:0] {
		wb_alu   = 3'd0,
		wb_load  = 3'd1,
		wb_pc    = 3'd2,
		wb_timer = 3'd3,
		wb_imm   = 3'd4
	} wb_sel_e;

	typedef enum logic {
		ms_run  = 1'b0,
		ms_halt = 1'b1
	} ms_state_e;

	// one instruction record in the MEM stage
	typedef struct packed {
		logic      reg_wen;
		reg_addr_t reg_waddr;
		xlen_t     alu_res;	// also the data address
		xlen_t     store_data;
		wmask_t    wmask;
		logic      s_flag;
		logic      time_set;
		imm_t      s_imm;
		ext_e      expand_signed;
		wb_sel_e   rd_buf_flag;
		logic      ebreak;
		pc_t       next_pc;
	} ex_mem_t;

	// register file write port
	typedef struct packed {
		logic      reg_wen;
		reg_addr_t reg_waddr;
		xlen_t     reg_wdata;
	} wb_t;

	// reset value of the EX/MEM register
	localparam ex_mem_t ex_mem_bubble = '{
		reg_wen:       1'b0,
		reg_waddr:     '0,
		alu_res:       '0,
		store_data:    '0,
		wmask:         '0,
		s_flag:        1'b0,
		time_set:      1'b0,
		s_imm:         '0,
		expand_signed: ext_b,
		rd_buf_flag:   wb_alu,
		ebreak:        1'b0,
		next_pc:       reset_pc
	};

endpackage

/* source/ex_mem_regs.sv */
`timescale 1ns/100ps

module ex_mem_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  rvseed_pkg::ex_mem_t ex_i,
	input  logic                bubble_i,
	output rvseed_pkg::ex_mem_t mem_o
);

	import rvseed_pkg::*;

	ex_mem_t rec_d;

	// squash everything with a side effect, payload passes as is
	always_comb begin
		rec_d = ex_i;
		if (bubble_i) begin
			rec_d.reg_wen  = 1'b0;
			rec_d.s_flag   = 1'b0;
			rec_d.time_set = 1'b0;
			rec_d.ebreak   = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_o <= ex_mem_bubble;
		end else begin
			mem_o <= rec_d;
		end
	end

endmodule

/* source/mem_ctrl.sv */
`timescale 1ns/100ps

module mem_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  rvseed_pkg::ex_mem_t mem_i,
	output logic                ram_we_o,
	output logic                tmr_we_o,
	output logic                bubble_o,
	output logic                halted_o,
	output logic                ebreak_o
);

	import rvseed_pkg::*;

	ms_state_e state_q;
	ms_state_e state_d;
	logic      run;

	assign run = (state_q == ms_run);

	// ebreak in MEM halts at the next edge, no way back except reset
	always_comb begin
		state_d = state_q;
		case (state_q)
			ms_run: begin
				if (mem_i.ebreak) begin
					state_d = ms_halt;
				end
			end
			ms_halt: state_d = ms_halt;
			default: state_d = ms_run;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ms_run;
		end else begin
			state_q <= state_d;
		end
	end

	// timer-set store goes to mtime, never to the RAM
	assign ram_we_o = run && mem_i.s_flag && !mem_i.time_set && (mem_i.wmask != '0);
	assign tmr_we_o = run && mem_i.s_flag && mem_i.time_set;

	// the record behind the ebreak is already squashed on the halt edge
	assign bubble_o = !run || mem_i.ebreak;
	assign halted_o = !run;
	assign ebreak_o = mem_i.ebreak;	// only one ebreak can reach MEM

	// relies on ex_mem_regs clearing ebreak in every later record
	a_no_ebreak_halted: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state_q == ms_halt) |-> !ebreak_o
	) else $error("ebreak seen while halted");

endmodule

/* mem_stage/data_ram.sv */
`timescale 1ns/100ps

module data_ram (
	input  logic              clk,
	input  logic              we_i,
	input  rvseed_pkg::xlen_t addr_i,
	input  rvseed_pkg::xlen_t wdata_i,
	input  rvseed_pkg::wmask_t wmask_i,
	output rvseed_pkg::xlen_t rd_word_o
);

	import rvseed_pkg::*;

	localparam int depth = 1 << ram_depth_log2;

	xlen_t                     mem [depth];
	logic [ram_depth_log2-1:0] word_idx;
	logic [2:0]                offset;
	wmask_t                    lane_en;
	xlen_t                     lane_data;

	assign word_idx = addr_i[ram_depth_log2+2:3];
	assign offset   = addr_i[2:0];

	// move mask and data up to the addressed byte lane
	assign lane_en   = wmask_i << offset;
	assign lane_data = wdata_i << {offset, 3'b000};

	always_ff @(posedge clk) begin
		for (int i = 0; i < 8; i++) begin
			if (we_i && lane_en[i]) begin
				mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
			end
		end
	end

	// asynchronous read, a store lands before the next record reads
	assign rd_word_o = mem[word_idx];

	// half needs bit 0 clear, word bits 1:0, double bits 2:0
	a_aligned_store: assert property (
		@(posedge clk)
		we_i |-> !((wmask_i[1] && offset[0]) ||
		           (wmask_i[3] && (offset[1:0] != 2'b00)) ||
		           (wmask_i[7] && (offset != 3'b000)))
	) else $error("misaligned store, addr %h mask %h", addr_i, wmask_i);

endmodule

/* mem_stage/load_extend.sv */
`timescale 1ns/100ps

module load_extend (
	input  rvseed_pkg::xlen_t word_i,
	input  logic [2:0]        offset_i,
	input  rvseed_pkg::ext_e  ext_i,
	output rvseed_pkg::xlen_t data_o
);

	import rvseed_pkg::*;

	xlen_t shifted;

	// addressed element down to bit 0
	assign shifted = word_i >> {offset_i, 3'b000};

	always_comb begin
		case (ext_i)
			ext_b:   data_o = {{56{shifted[7]}}, shifted[7:0]};
			ext_bu:  data_o = {56'd0, shifted[7:0]};
			ext_h:   data_o = {{48{shifted[15]}}, shifted[15:0]};
			ext_hu:  data_o = {48'd0, shifted[15:0]};
			ext_w:   data_o = {{32{shifted[31]}}, shifted[31:0]};
			ext_wu:  data_o = {32'd0, shifted[31:0]};
			ext_d:   data_o = shifted;	// offset is zero here
			default: data_o = shifted;
		endcase
	end

endmodule

/* source/mtime_counter.sv */
`timescale 1ns/100ps

module mtime_counter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              run_i,
	input  logic              we_i,
	input  rvseed_pkg::xlen_t wdata_i,
	output rvseed_pkg::xlen_t mtime_o
);

	// frozen while halted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime_o <= '0;
		end else if (run_i) begin
			if (we_i) begin
				mtime_o <= wdata_i;	// timer-set store wins over the tick
			end else begin
				mtime_o <= mtime_o + 1'b1;
			end
		end
	end

endmodule

/* source/mem_wb_regs.sv */
`timescale 1ns/100ps

module mem_wb_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  rvseed_pkg::ex_mem_t mem_i,
	input  rvseed_pkg::xlen_t   load_data_i,
	input  rvseed_pkg::xlen_t   mtime_i,
	output rvseed_pkg::wb_t     wb_o
);

	import rvseed_pkg::*;

	xlen_t     wdata_d;
	logic      wen_q;
	reg_addr_t waddr_q;
	xlen_t     wdata_q;

	always_comb begin
		case (mem_i.rd_buf_flag)
			wb_alu:   wdata_d = mem_i.alu_res;
			wb_load:  wdata_d = load_data_i;
			wb_pc:    wdata_d = {32'd0, mem_i.next_pc};
			wb_timer: wdata_d = mtime_i;	// value held this cycle
			wb_imm:   wdata_d = {{32{mem_i.s_imm[31]}}, mem_i.s_imm};
			default:  wdata_d = mem_i.alu_res;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wen_q <= 1'b0;
		end else begin
			wen_q <= mem_i.reg_wen;	// x0 writes go out, regfile drops them
		end
	end

	always_ff @(posedge clk) begin
		waddr_q <= mem_i.reg_waddr;
		wdata_q <= wdata_d;
	end

	assign wb_o = '{reg_wen: wen_q, reg_waddr: waddr_q, reg_wdata: wdata_q};

endmodule

/* source/mem_stage_top.sv */
`timescale 1ns/100ps

module mem_stage_top (
	input  logic                clk,
	input  logic                rst_n,
	input  rvseed_pkg::ex_mem_t ex_i,
	output rvseed_pkg::wb_t     wb_o,
	output logic                halted_o,
	output logic                ebreak_o
);

	import rvseed_pkg::*;

	ex_mem_t mem_rec;
	logic    ram_we;
	logic    tmr_we;
	logic    bubble;
	xlen_t   rd_word;
	xlen_t   load_data;
	xlen_t   mtime;

	ex_mem_regs i_ex_mem_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_i     (ex_i),
		.bubble_i (bubble),
		.mem_o    (mem_rec)
	);

	mem_ctrl i_mem_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem_i    (mem_rec),
		.ram_we_o (ram_we),
		.tmr_we_o (tmr_we),
		.bubble_o (bubble),
		.halted_o (halted_o),
		.ebreak_o (ebreak_o)
	);

	data_ram i_data_ram (
		.clk       (clk),
		.we_i      (ram_we),
		.addr_i    (mem_rec.alu_res),
		.wdata_i   (mem_rec.store_data),
		.wmask_i   (mem_rec.wmask),
		.rd_word_o (rd_word)
	);

	load_extend i_load_extend (
		.word_i   (rd_word),
		.offset_i (mem_rec.alu_res[2:0]),
		.ext_i    (mem_rec.expand_signed),
		.data_o   (load_data)
	);

	mtime_counter i_mtime_counter (
		.clk     (clk),
		.rst_n   (rst_n),
		.run_i   (~halted_o),
		.we_i    (tmr_we),
		.wdata_i (mem_rec.store_data),
		.mtime_o (mtime)
	);

	mem_wb_regs i_mem_wb_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_i       (mem_rec),
		.load_data_i (load_data),
		.mtime_i     (mtime),
		.wb_o        (wb_o)
	);

endmodule

/* bench/mem_stage_tb.sv */
`timescale 1ns/100ps

module mem_stage_tb;

	import rvseed_pkg::*;

	localparam int n_wb   = 60;	// writeback source records
	localparam int n_mem  = 100;	// store/load pairs
	localparam int n_tmr  = 8;	// timer loads, 5 reads each
	localparam int n_pre  = 10;
	localparam int n_post = 24;	// stores issued after the halt
	localparam int cycle_limit = 2 * 9 + 5 * 2 + 4 + n_wb + 256 + 2 * n_mem + 3 + 6 * n_tmr
		+ n_pre + 1 + n_post + 2 + n_post + 50;

	logic    clk;
	logic    rst_n;
	ex_mem_t ex_i;
	wb_t     wb_o;
	logic    halted_o;
	logic    ebreak_o;

	integer seed;
	int     cycle_cnt;
	int     err_count;
	int     err_mark;
	int     check_count;
	int     tests_run;
	int     tests_bad;

	// reference model state
	logic [7:0] ram_b [0:2047];	// byte view of the data RAM
	xlen_t      mtime_m;
	logic       halt_m;
	wb_t        exp_q [$];
	logic       halted_next;
	logic       ebreak_next;
	xlen_t      post_addr [$];

	mem_stage_top i_mem_stage_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_i     (ex_i),
		.wb_o     (wb_o),
		.halted_o (halted_o),
		.ebreak_o (ebreak_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	task automatic check_wb(input wb_t exp, input wb_t act);
		check_count++;
		if (act.reg_wen !== exp.reg_wen || (exp.reg_wen &&
			(act.reg_waddr !== exp.reg_waddr || act.reg_wdata !== exp.reg_wdata))) begin
			$display("ERROR %0t wb_o: expected wen %b rd %0d data %h, actual wen %b rd %0d data %h",
				$time, exp.reg_wen, exp.reg_waddr, exp.reg_wdata,
				act.reg_wen, act.reg_waddr, act.reg_wdata);
			err_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			$display("ERROR %0t %s: expected %b actual %b", $time, name, exp, act);
			err_count++;
		end
	endtask

	function automatic xlen_t rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic xlen_t rand_addr(input int size);
		xlen_t a;
		a = '0;
		a[10:0] = $random(seed);
		a[10:0] = a[10:0] & ~(size - 1);	// size aligned, inside the RAM
		return a;
	endfunction

	function automatic int ext_size(input ext_e code);
		case (code)
			ext_b, ext_bu: return 1;
			ext_h, ext_hu: return 2;
			ext_w, ext_wu: return 4;
			default:       return 8;
		endcase
	endfunction

	function automatic wmask_t mask_for(input int size);
		return wmask_t'((1 << size) - 1);
	endfunction

	function automatic ex_mem_t idle_rec();
		ex_mem_t r;
		r = '0;
		r.expand_signed = ext_d;
		r.rd_buf_flag = wb_alu;
		return r;
	endfunction

	// random payload, no side effects
	function automatic ex_mem_t rand_plain();
		ex_mem_t r;
		r = idle_rec();
		r.reg_wen = 1'b1;
		r.reg_waddr = $random(seed);
		r.alu_res = rand64();
		r.store_data = rand64();
		r.s_imm = $random(seed);
		r.next_pc = $random(seed);
		return r;
	endfunction

	function automatic ex_mem_t rand_store(input int size);
		ex_mem_t r;
		r = rand_plain();
		r.reg_wen = $random(seed);
		r.alu_res = rand_addr(size);
		r.wmask = mask_for(size);
		r.s_flag = 1'b1;
		return r;
	endfunction

	function automatic ex_mem_t load_rec(input ext_e code, input xlen_t addr);
		ex_mem_t r;
		r = rand_plain();
		r.alu_res = addr;
		r.expand_signed = code;
		r.rd_buf_flag = wb_load;
		return r;
	endfunction

	function automatic xlen_t model_load(input xlen_t addr, input ext_e code);
		logic [10:0] a;
		xlen_t       v;
		int          n;
		v = '0;
		n = ext_size(code);
		for (int i = 0; i < n; i++) begin
			a = addr[10:0] + i;
			v[8*i +: 8] = ram_b[a];
		end
		if ((code == ext_b || code == ext_h || code == ext_w) && v[8*n-1]) begin
			for (int i = n; i < 8; i++) begin
				v[8*i +: 8] = 8'hff;
			end
		end
		return v;
	endfunction

	// record as it passes through MEM, in issue order
	task automatic apply_rec(input ex_mem_t r);
		wb_t         exp;
		logic [10:0] a;
		if (halt_m) begin
			r.reg_wen = 1'b0;
			r.s_flag = 1'b0;
			r.time_set = 1'b0;
			r.ebreak = 1'b0;
		end
		exp.reg_wen = r.reg_wen;
		exp.reg_waddr = r.reg_waddr;
		case (r.rd_buf_flag)
			wb_load:  exp.reg_wdata = model_load(r.alu_res, r.expand_signed);
			wb_pc:    exp.reg_wdata = xlen_t'(r.next_pc);
			wb_timer: exp.reg_wdata = mtime_m;
			wb_imm:   exp.reg_wdata = xlen_t'($signed(r.s_imm));
			default:  exp.reg_wdata = r.alu_res;
		endcase
		exp_q.push_back(exp);
		ebreak_next = r.ebreak;
		halted_next = halt_m;
		if (!halt_m) begin
			if (r.s_flag && r.time_set) begin
				mtime_m = r.store_data;
			end else begin
				for (int i = 0; i < 8; i++) begin
					a = r.alu_res[10:0] + i;
					if (r.s_flag && r.wmask[i]) ram_b[a] = r.store_data[8*i +: 8];
				end
				mtime_m = mtime_m + 1;
			end
		end
		if (r.ebreak) halt_m = 1'b1;
	endtask

	// check what the last edges produced, then drive the next record
	task automatic step(input ex_mem_t r);
		@(negedge clk);
		if (exp_q.size() == 0) begin
			$display("model queue ran empty at %0t", $time);
			err_count++;
		end else begin
			check_wb(exp_q.pop_front(), wb_o);
		end
		check_bit("halted_o", halted_next, halted_o);
		check_bit("ebreak_o", ebreak_next, ebreak_o);
		ex_i = r;
		apply_rec(r);
	endtask

	task automatic do_reset();
		@(negedge clk);
		rst_n = 1'b0;
		ex_i = idle_rec();
		repeat (8) @(negedge clk);
		check_bit("wb_o.reg_wen", 1'b0, wb_o.reg_wen);
		check_bit("halted_o", 1'b0, halted_o);
		check_bit("ebreak_o", 1'b0, ebreak_o);
		rst_n = 1'b1;
		exp_q.delete();
		halt_m = 1'b0;
		mtime_m = '0;
		apply_rec(idle_rec());	// reset bubble in MEM
		apply_rec(ex_i);	// idle record held through reset
	endtask

	task automatic finish_test(input string name);
		int n;
		step(idle_rec());
		step(idle_rec());
		n = err_count - err_mark;
		tests_run++;
		if (n == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d mismatches", name, n);
		end
		err_mark = err_count;
	endtask

	initial begin
		ex_mem_t r;
		ext_e    code;
		seed = 94;
		rst_n = 1'b0;
		ex_i = idle_rec();
		cycle_cnt = 0;
		err_count = 0;
		err_mark = 0;
		check_count = 0;
		tests_run = 0;
		tests_bad = 0;
		halt_m = 1'b0;
		mtime_m = '0;

		do_reset();
		repeat (4) step(idle_rec());
		finish_test("reset_values");

		for (int i = 0; i < n_wb; i++) begin
			r = rand_plain();
			r.reg_wen = ({$random(seed)} % 4) != 0;
			case ({$random(seed)} % 3)
				0:       r.rd_buf_flag = wb_alu;
				1:       r.rd_buf_flag = wb_pc;
				default: r.rd_buf_flag = wb_imm;
			endcase
			step(r);
		end
		finish_test("wb_sources");

		for (int i = 0; i < 256; i++) begin
			r = rand_store(8);	// known contents everywhere
			r.alu_res = xlen_t'(i) << 3;
			step(r);
		end
		for (int i = 0; i < n_mem; i++) begin
			r = rand_store(1 << ({$random(seed)} % 4));
			step(r);
			code = ext_e'({$random(seed)} % 7);
			if ($random(seed) & 1) begin
				step(load_rec(code, r.alu_res & ~xlen_t'(ext_size(code) - 1)));
			end else begin
				step(load_rec(code, rand_addr(ext_size(code))));
			end
		end
		finish_test("store_load");

		for (int i = 0; i < 3 + 6 * n_tmr; i++) begin
			if (i >= 3 && (i - 3) % 6 == 0) begin
				r = rand_store(8);
				r.time_set = 1'b1;
			end else begin
				r = rand_plain();
				r.rd_buf_flag = wb_timer;
			end
			step(r);
		end
		finish_test("timer");

		repeat (n_pre) step(rand_plain());
		r = rand_plain();
		r.ebreak = 1'b1;
		step(r);
		post_addr.delete();
		for (int i = 0; i < n_post; i++) begin
			r = rand_store(1 << ({$random(seed)} % 4));
			r.reg_wen = 1'b1;
			post_addr.push_back(r.alu_res & ~xlen_t'(7));
			step(r);
		end
		step(idle_rec());
		step(idle_rec());
		do_reset();	// RAM keeps its contents
		foreach (post_addr[i]) step(load_rec(ext_d, post_addr[i]));
		finish_test("ebreak_halt");

		$display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
			tests_run, tests_bad, check_count, err_count);
		if (tests_bad == 0 && err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* src.f */
common/rvseed_pkg.sv
source/ex_mem_regs.sv
source/mem_ctrl.sv
mem_stage/data_ram.sv
mem_stage/load_extend.sv
source/mtime_counter.sv
source/mem_wb_regs.sv
source/mem_stage_top.sv
bench/mem_stage_tb.sv
